// File: include/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Bus widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32

// Destination register number
`define LSU_REG_W 5

// Pending request slots, power of two
`define LSU_QUEUE_DEPTH 4

`endif

// File: verilog/lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

	//****************************************
	// Access size
	//****************************************
	// Encoding 3 is unused and behaves as long
	typedef enum logic [1:0] {
		SZ_BYTE = 2'd0,
		SZ_WORD = 2'd1,
		SZ_LONG = 2'd2
	} mem_size_e;

	//****************************************
	// Byte lanes
	//****************************************
	// Big-endian lane order
	// bit 3 is bus bits 31:24, the byte at offset 0
	typedef logic [3:0] lane_t;

	//****************************************
	// Request control
	//****************************************
	typedef struct packed {
		logic                  write;
		mem_size_e             size;
		logic [`LSU_REG_W-1:0] dest;
	} mem_ctl_t;

endpackage

// File: verilog/lsu_req_if.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

interface lsu_req_if;
	import lsu_pkg::*;

	logic                   valid;
	logic                   take;
	logic [`LSU_ADDR_W-1:0] addr;
	lane_t                  lanes;
	// Already replicated into the enabled lanes
	logic [`LSU_DATA_W-1:0] data;
	mem_ctl_t               ctl;

	modport source (
		output valid, addr, lanes, data, ctl,
		input  take
	);

	modport sink (
		input  valid, addr, lanes, data, ctl,
		output take
	);

endinterface

// File: verilog/mem_req_issue.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module mem_req_issue (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  logic                   req_valid,
	input  logic                   req_write,
	input  lsu_pkg::mem_size_e     req_size,
	input  logic [`LSU_ADDR_W-1:0] req_addr,
	input  logic [`LSU_DATA_W-1:0] req_wdata,
	input  logic [`LSU_REG_W-1:0]  req_dest,
	output logic                   req_full,
	lsu_req_if.source              out
);
	import lsu_pkg::*;

	logic                   hold_valid;
	logic                   load_en;
	lane_t                  new_lanes;
	logic [`LSU_DATA_W-1:0] new_data;
	mem_ctl_t               new_ctl;
	logic [`LSU_ADDR_W-1:0] hold_addr;
	lane_t                  hold_lanes;
	logic [`LSU_DATA_W-1:0] hold_data;
	mem_ctl_t               hold_ctl;

	// Stage busy and the queue is not taking
	assign req_full = hold_valid & ~out.take;
	assign load_en  = req_valid & ~req_full;

	// Lane enables and write data replication
	always_comb begin
		case (req_size)
			SZ_BYTE: begin
				new_lanes = 4'b1000 >> req_addr[1:0];
				new_data  = {4{req_wdata[7:0]}};
			end
			SZ_WORD: begin
				new_lanes = req_addr[1] ? 4'b0011 : 4'b1100;
				new_data  = {2{req_wdata[15:0]}};
			end
			default: begin
				new_lanes = 4'b1111;
				new_data  = req_wdata;
			end
		endcase
	end

	assign new_ctl = '{write: req_write, size: req_size, dest: req_dest};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			hold_valid <= 1'b0;
		end else if (load_en) begin
			hold_valid <= 1'b1;
		end else if (out.take) begin
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (load_en) begin
			hold_addr  <= req_addr;
			hold_lanes <= new_lanes;
			hold_data  <= new_data;
			hold_ctl   <= new_ctl;
		end
	end

	assign out.valid = hold_valid;
	assign out.addr  = hold_addr;
	assign out.lanes = hold_lanes;
	assign out.data  = hold_data;
	assign out.ctl   = hold_ctl;

endmodule

// File: verilog/mem_req_queue.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module mem_req_queue #(
	parameter int DEPTH = `LSU_QUEUE_DEPTH
) (
	input  logic      CLK,
	input  logic      RST_N,
	lsu_req_if.sink   in,
	lsu_req_if.source out
);
	import lsu_pkg::*;

	localparam int PTR_W = $clog2(DEPTH);

	logic [`LSU_ADDR_W-1:0] addr_mem  [DEPTH];
	lane_t                  lanes_mem [DEPTH];
	logic [`LSU_DATA_W-1:0] data_mem  [DEPTH];
	mem_ctl_t               ctl_mem   [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             full;
	logic             push;
	logic             pop;

	assign full = (count == (PTR_W+1)'(DEPTH));
	assign pop  = out.valid & out.take;
	// A full queue still accepts when the head leaves this cycle
	assign in.take = ~full | out.take;
	assign push = in.valid & in.take;

	//****************************************
	// Pointers and occupancy
	//****************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Entry storage
	always_ff @(posedge CLK) begin
		if (push) begin
			addr_mem[wr_ptr]  <= in.addr;
			lanes_mem[wr_ptr] <= in.lanes;
			data_mem[wr_ptr]  <= in.data;
			ctl_mem[wr_ptr]   <= in.ctl;
		end
	end

	// Oldest entry
	assign out.valid = (count != '0);
	assign out.addr  = addr_mem[rd_ptr];
	assign out.lanes = lanes_mem[rd_ptr];
	assign out.data  = data_mem[rd_ptr];
	assign out.ctl   = ctl_mem[rd_ptr];

endmodule

// File: verilog/bus_cycle_ctrl.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module bus_cycle_ctrl (
	input  logic                   CLK,
	input  logic                   RST_N,
	lsu_req_if.sink                in,
	output logic [`LSU_ADDR_W-1:0] bus_a,
	output logic [`LSU_DATA_W-1:0] bus_do,
	output lsu_pkg::lane_t         bus_ba,
	output logic                   bus_wr,
	output logic                   bus_req,
	input  logic [`LSU_DATA_W-1:0] bus_di,
	input  logic                   bus_wait,
	output logic                   rd_valid,
	output logic [`LSU_DATA_W-1:0] rd_data,
	output logic [`LSU_REG_W-1:0]  rd_dest
);
	import lsu_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_ACTIVE
	} state_e;

	state_e                 state;
	logic                   start;
	logic                   done;
	logic [`LSU_ADDR_W-1:0] acc_addr;
	lane_t                  acc_lanes;
	logic [`LSU_DATA_W-1:0] acc_data;
	mem_ctl_t               acc_ctl;
	logic [1:0]             byte_mask;
	logic [1:0]             shift;
	logic [`LSU_DATA_W-1:0] shifted;
	logic [`LSU_DATA_W-1:0] load_data;

	assign in.take = (state == ST_IDLE);
	assign start   = in.valid & (state == ST_IDLE);
	assign done    = (state == ST_ACTIVE) & ~bus_wait;

	//****************************************
	// Access sequencer
	//****************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE:   if (start) state <= ST_ACTIVE;
				ST_ACTIVE: if (done) state <= ST_IDLE;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	// Held for the whole access
	always_ff @(posedge CLK) begin
		if (start) begin
			acc_addr  <= in.addr;
			acc_lanes <= in.lanes;
			acc_data  <= in.data;
			acc_ctl   <= in.ctl;
		end
	end

	assign bus_req = (state == ST_ACTIVE);
	assign bus_wr  = bus_req & acc_ctl.write;
	assign bus_a   = acc_addr;
	assign bus_ba  = acc_lanes;
	assign bus_do  = acc_data;

	//****************************************
	// Load alignment
	//****************************************
	always_comb begin
		case (acc_ctl.size)
			SZ_BYTE: byte_mask = 2'b11;
			SZ_WORD: byte_mask = 2'b10;
			default: byte_mask = 2'b00;
		endcase
	end

	// Bytes below the addressed one in big-endian order
	assign shift   = ~acc_addr[1:0] & byte_mask;
	assign shifted = bus_di >> {shift, 3'b000};

	always_comb begin
		case (acc_ctl.size)
			SZ_BYTE: load_data = {{24{shifted[7]}}, shifted[7:0]};
			SZ_WORD: load_data = {{16{shifted[15]}}, shifted[15:0]};
			default: load_data = shifted;
		endcase
	end

	// Response, loads only
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= done & ~acc_ctl.write;
		end
	end

	always_ff @(posedge CLK) begin
		if (done) begin
			rd_data <= load_data;
			rd_dest <= acc_ctl.dest;
		end
	end

endmodule

// File: verilog/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_top (
	input  logic                   CLK,
	input  logic                   RST_N,

	// Client request
	input  logic                   req_valid,
	input  logic                   req_write,
	input  lsu_pkg::mem_size_e     req_size,
	input  logic [`LSU_ADDR_W-1:0] req_addr,
	input  logic [`LSU_DATA_W-1:0] req_wdata,
	input  logic [`LSU_REG_W-1:0]  req_dest,
	output logic                   req_full,

	// Memory bus
	output logic [`LSU_ADDR_W-1:0] bus_a,
	output logic [`LSU_DATA_W-1:0] bus_do,
	output lsu_pkg::lane_t         bus_ba,
	output logic                   bus_wr,
	output logic                   bus_req,
	input  logic [`LSU_DATA_W-1:0] bus_di,
	input  logic                   bus_wait,

	// Load result
	output logic                   rd_valid,
	output logic [`LSU_DATA_W-1:0] rd_data,
	output logic [`LSU_REG_W-1:0]  rd_dest
);
	import lsu_pkg::*;

	lsu_req_if issue_q ();
	lsu_req_if q_bus ();

	//****************************************
	// Request capture
	//****************************************
	mem_req_issue i_issue (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.req_valid (req_valid),
		.req_write (req_write),
		.req_size  (req_size),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_dest  (req_dest),
		.req_full  (req_full),
		.out       (issue_q.source)
	);

	// Pending requests in order
	mem_req_queue #(
		.DEPTH (`LSU_QUEUE_DEPTH)
	) i_queue (
		.CLK   (CLK),
		.RST_N (RST_N),
		.in    (issue_q.sink),
		.out   (q_bus.source)
	);

	//****************************************
	// Bus access
	//****************************************
	bus_cycle_ctrl i_bus (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.in       (q_bus.sink),
		.bus_a    (bus_a),
		.bus_do   (bus_do),
		.bus_ba   (bus_ba),
		.bus_wr   (bus_wr),
		.bus_req  (bus_req),
		.bus_di   (bus_di),
		.bus_wait (bus_wait),
		.rd_valid (rd_valid),
		.rd_data  (rd_data),
		.rd_dest  (rd_dest)
	);

endmodule

// File: dv/tb_bus_mem.sv
`timescale 1ns/1ps

module tb_bus_mem #(
	parameter int SEED = 69315
) (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        bus_req,
	input  logic        bus_wr,
	input  logic [31:0] bus_a,
	input  logic [3:0]  bus_ba,
	input  logic [31:0] bus_do,
	input  logic        force_wait,
	output logic [31:0] bus_di,
	output logic        bus_wait
);
	logic [31:0] mem [64];
	// Completed accesses as {wr, addr, lanes, write data}
	logic [68:0] log_q [$];
	logic [1:0]  wait_left;
	logic [31:0] rnd;
	integer      seed = SEED;
	int          i;

	// Byte at address A holds A xor C3
	function automatic logic [31:0] fill_word(input logic [5:0] idx);
		logic [7:0] b;
		b = {idx, 2'b00};
		return {b, b + 8'd1, b + 8'd2, b + 8'd3} ^ 32'hC3C3_C3C3;
	endfunction

	assign bus_di = mem[bus_a[7:2]];

	always @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (i = 0; i < 64; i++) begin
				mem[i] <= fill_word(6'(i));
			end
			wait_left <= 2'd0;
			bus_wait  <= 1'b0;
		end else if (bus_req && !bus_wait) begin
			if (bus_wr) begin
				for (i = 0; i < 4; i++) begin
					if (bus_ba[i]) begin
						mem[bus_a[7:2]][8*i +: 8] <= bus_do[8*i +: 8];
					end
				end
			end
			log_q.push_back({bus_wr, bus_a, bus_ba, bus_do});
			// Wait length for the next access
			rnd = $random(seed);
			wait_left <= rnd[1:0];
			bus_wait  <= (rnd[1:0] != 2'd0) || force_wait;
		end else if (bus_req) begin
			wait_left <= (wait_left != 2'd0) ? wait_left - 2'd1 : 2'd0;
			bus_wait  <= (wait_left > 2'd1) || force_wait;
		end else begin
			bus_wait <= (wait_left != 2'd0) || force_wait;
		end
	end

endmodule

// File: dv/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;
	import lsu_pkg::*;

	localparam int TIMEOUT = 200;

	logic        CLK;
	logic        RST_N;
	logic        req_valid;
	logic        req_write;
	mem_size_e   req_size;
	logic [31:0] req_addr;
	logic [31:0] req_wdata;
	logic [4:0]  req_dest;
	logic        req_full;
	logic [31:0] bus_a;
	logic [31:0] bus_do;
	lane_t       bus_ba;
	logic        bus_wr;
	logic        bus_req;
	logic [31:0] bus_di;
	logic        bus_wait;
	logic        rd_valid;
	logic [31:0] rd_data;
	logic [4:0]  rd_dest;
	logic        force_wait;

	integer      seed;
	logic [31:0] shadow [64];
	logic [68:0] exp_bus_q [$];
	logic [36:0] exp_rd_q [$];
	int          n_checks = 0;
	int          n_errors = 0;
	int          loads_done = 0;
	int          rd_seen = 0;
	bit          saw_full = 1'b0;
	event        run_end;

	lsu_top i_dut (.*);

	tb_bus_mem #(.SEED(69315)) i_mem (.*);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	//****************************************
	// Reference model
	//****************************************
	function automatic logic [31:0] fill_word(input logic [5:0] idx);
		logic [7:0] b;
		b = {idx, 2'b00};
		return {b, b + 8'd1, b + 8'd2, b + 8'd3} ^ 32'hC3C3_C3C3;
	endfunction

	// Returns {lanes, bus write data}
	function automatic logic [35:0] exp_bus(input logic [1:0] size, input logic [31:0] addr,
		input logic [31:0] wdata);
		logic [3:0]  ba;
		logic [31:0] data;
		int          k;
		ba = 4'b0000;
		// Lane k carries the byte at offset 3 - k
		for (k = 0; k < 4; k++) begin
			case (size)
				2'd0: begin
					ba[k] = ((3 - k) == int'(addr[1:0]));
					data[8*k +: 8] = wdata[7:0];
				end
				2'd1: begin
					ba[k] = (((3 - k) / 2) == int'(addr[1]));
					data[8*k +: 8] = wdata[8*(k % 2) +: 8];
				end
				default: begin
					ba[k] = 1'b1;
					data[8*k +: 8] = wdata[8*k +: 8];
				end
			endcase
		end
		return {ba, data};
	endfunction

	function automatic logic [31:0] exp_load(input logic [31:0] addr, input logic [1:0] size);
		logic [31:0] w;
		logic [7:0]  b;
		logic [15:0] h;
		int          sh;
		w = shadow[addr[7:2]];
		// Offset 0 is the top byte
		sh = 8 * (3 - int'(addr[1:0]));
		b = w[sh +: 8];
		h = addr[1] ? w[15:0] : w[31:16];
		case (size)
			2'd0: return {{24{b[7]}}, b};
			2'd1: return {{16{h[15]}}, h};
			default: return w;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, want);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		n_errors++;
		$display("Timeout: %s", what);
		-> run_end;
	endtask

	//****************************************
	// Stimulus
	//****************************************
	task automatic issue(input logic w, input logic [1:0] size, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [4:0] dest);
		logic [35:0] bus;
		int          n;
		int          k;
		bus = exp_bus(size, addr, wdata);
		exp_bus_q.push_back({w, addr, bus});
		if (w) begin
			for (k = 0; k < 4; k++) begin
				if (bus[32 + k]) begin
					shadow[addr[7:2]][8*k +: 8] = bus[8*k +: 8];
				end
			end
		end else begin
			exp_rd_q.push_back({dest, exp_load(addr, size)});
		end
		@(posedge CLK);
		req_valid <= 1'b1;
		req_write <= w;
		req_size  <= mem_size_e'(size);
		req_addr  <= addr;
		req_wdata <= wdata;
		req_dest  <= dest;
		// Strobe is taken on the edge after a cycle with req_full low
		n = 0;
		@(negedge CLK);
		while (req_full && n < TIMEOUT) begin
			saw_full = 1'b1;
			@(negedge CLK);
			n++;
		end
		if (req_full) stop_on_timeout("req_full stayed high");
	endtask

	task automatic issue_random();
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] d;
		r = $random(seed);
		a = $random(seed);
		d = $random(seed);
		issue(r[0], r[3:2], {24'd0, a[7:0]}, d, r[12:8]);
	endtask

	task automatic idle();
		@(posedge CLK);
		req_valid <= 1'b0;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((exp_bus_q.size() != 0 || exp_rd_q.size() != 0) && n < TIMEOUT) begin
			@(negedge CLK);
			n++;
		end
		if (exp_bus_q.size() != 0 || exp_rd_q.size() != 0) stop_on_timeout("requests pending");
	endtask

	task automatic finish_test(input int num, input string name, input int err_start);
		drain();
		$display("Test %0d %s: %0d errors", num, name, n_errors - err_start);
	endtask

	//****************************************
	// Response comparison
	//****************************************
	initial begin : compare
		logic [68:0] got;
		logic [68:0] want;
		logic [36:0] rsp;
		forever begin
			@(negedge CLK);
			while (i_mem.log_q.size() != 0) begin
				got = i_mem.log_q.pop_front();
				if (exp_bus_q.size() == 0) begin
					n_errors++;
					$display("Bus access to 0x%08h with no request pending", got[67:36]);
				end else begin
					want = exp_bus_q.pop_front();
					check("bus_wr", 32'(got[68]), 32'(want[68]));
					check("bus_a", got[67:36], want[67:36]);
					check("bus_ba", 32'(got[35:32]), 32'(want[35:32]));
					if (want[68]) check("bus_do", got[31:0], want[31:0]);
					if (!got[68]) loads_done++;
				end
			end
			if (rd_valid) begin
				if (exp_rd_q.size() == 0 || rd_seen >= loads_done) begin
					n_errors++;
					$display("rd_valid seen before any matching load completed");
				end else begin
					rsp = exp_rd_q.pop_front();
					rd_seen++;
					check("rd_data", rd_data, rsp[31:0]);
					check("rd_dest", 32'(rd_dest), 32'(rsp[36:32]));
				end
			end
		end
	end

	//****************************************
	// End of run
	//****************************************
	initial begin : end_of_run
		@(run_end);
		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		int i;
		int err0;
		logic [31:0] r;
		seed       = 69315;
		RST_N      = 1'b0;
		req_valid  = 1'b0;
		req_write  = 1'b0;
		req_size   = SZ_BYTE;
		req_addr   = 32'd0;
		req_wdata  = 32'd0;
		req_dest   = 5'd0;
		force_wait = 1'b0;
		for (i = 0; i < 64; i++) begin
			shadow[i] = fill_word(6'(i));
		end
		repeat (16) @(posedge CLK);
		RST_N <= 1'b1;

		err0 = n_errors;
		@(negedge CLK);
		check("bus_req", 32'(bus_req), 32'd0);
		check("bus_wr", 32'(bus_wr), 32'd0);
		check("rd_valid", 32'(rd_valid), 32'd0);
		check("req_full", 32'(req_full), 32'd0);
		finish_test(1, "reset state", err0);

		// Each size and offset into its own word, then read back whole
		err0 = n_errors;
		for (i = 0; i < 12; i++) begin
			r = $random(seed);
			issue(1'b1, 2'(i / 4), {24'd0, 6'(i + 8), 2'(i % 4)}, r, 5'd0);
		end
		for (i = 0; i < 12; i++) begin
			issue(1'b0, 2'd2, {24'd0, 6'(i + 8), 2'b00}, 32'd0, 5'(i));
		end
		idle();
		finish_test(2, "store lanes", err0);

		err0 = n_errors;
		for (i = 0; i < 32; i++) begin
			issue(1'b0, 2'(i / 8), {24'd0, 6'((i % 8 < 4) ? 20 : 40), 2'(i % 4)},
				32'd0, 5'(i));
		end
		idle();
		finish_test(3, "load alignment", err0);

		err0 = n_errors;
		repeat (200) issue_random();
		idle();
		finish_test(4, "random mix", err0);

		// Bus held off while requests pile up
		err0 = n_errors;
		saw_full = 1'b0;
		@(posedge CLK);
		force_wait <= 1'b1;
		fork
			begin
				repeat (20) @(posedge CLK);
				force_wait <= 1'b0;
			end
			begin
				for (i = 0; i < 10; i++) begin
					issue_random();
				end
				idle();
			end
		join
		if (!saw_full) begin
			n_errors++;
			$display("req_full never rose while the bus was held");
		end
		finish_test(5, "back-pressure", err0);

		-> run_end;
	end

endmodule

// File: sim.f
+incdir+include
verilog/lsu_pkg.sv
verilog/lsu_req_if.sv
verilog/mem_req_issue.sv
verilog/mem_req_queue.sv
verilog/bus_cycle_ctrl.sv
verilog/lsu_top.sv
dv/tb_bus_mem.sv
dv/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module lsu_tb -o lsu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build did not complete"
	exit 1
fi

out=$(./obj_dir/lsu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1
